// ==== build.f ====
oled_pkg.sv
oled_item_if.sv
oled_byte_if.sv
wave_label_rotator.sv
screen_sequencer.sv
glyph_expander.sv
oled_serializer.sv
oled_display_top.sv
oled_sva.sv
oled_checker.sv
tb_oled.sv

// ==== Makefile ====
SIM ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_oled
FILE_LIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_oled.sv ====
// oled display testbench driving BCD inputs and building the expected panel byte stream
`timescale 1ns/10ps
module tb_oled;
	import oled_pkg::*;

	localparam int power_len = init_groups * glyph_bytes + text_rows * (glyph_bytes + clear_bytes);
	localparam int pass_len = ((1 + 4 + freq_digits + 2) + (1 + 3 + amp_digits + 2) + 9) *
		glyph_bytes;
	localparam int pass_goal = 18;
	localparam int wait_limit = 400_000;  // clk_in cycles

	typedef logic [8:0] stream_q [$];

	logic clk_in;
	logic rst_n_in;
	logic [4*freq_digits-1:0] freq_bcd;
	logic [4*amp_digits-1:0] amp_bcd;
	logic oled_rst_n;
	logic oled_cs_n;
	logic oled_dc;
	logic oled_clk;
	logic oled_data;
	logic [8:0] power_ref [0:power_len-1];
	logic [8:0] pass_ref [0:3*pass_len-1];
	stream_q power_q;
	int change_cnt;  // raised on every input change
	int passes_done;
	int tests_run;
	int tests_failed;
	logic chk_finished;
	bit ok;
	int k;
	int i;

	oled_display_top #(
		.rotate_cycles(200_000)
	) dut (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.freq_bcd(freq_bcd),
		.amp_bcd(amp_bcd),
		.oled_rst_n(oled_rst_n),
		.oled_cs_n(oled_cs_n),
		.oled_dc(oled_dc),
		.oled_clk(oled_clk),
		.oled_data(oled_data)
	);

	oled_checker #(
		.power_len(power_len),
		.pass_len(pass_len),
		.pass_goal(pass_goal)
	) u_checker (
		.clk_in(clk_in),
		.oled_rst_n(oled_rst_n),
		.oled_cs_n(oled_cs_n),
		.oled_dc(oled_dc),
		.oled_clk(oled_clk),
		.oled_data(oled_data),
		.power_ref(power_ref),
		.pass_ref(pass_ref),
		.change_cnt(change_cnt),
		.passes_done(passes_done),
		.tests_run(tests_run),
		.tests_failed(tests_failed),
		.finished(chk_finished)
	);

	function automatic glyph_code_t char_code(input byte c);
		if (c >= "0" && c <= "9")
			return glyph_code_t'(c - "0");
		if (c == ":")
			return 7'd26;
		return glyph_code_t'(c - "A" + 33);  // capitals start at 33
	endfunction

	// '|' is the next row position group, 'f' and 'a' take the next BCD digit
	function automatic stream_q expected_stream(input bit power_up, input logic [35:0] freq,
			input logic [19:0] amp, input int label_idx);
		stream_q q;
		logic [9:0] items [$];  // {cmd, row clear, blank cell, code}
		string script;
		string words [3];
		logic [3:0] nib;
		int grp;
		int fd;
		int ad;
		int n;
		int p;
		words = '{"SINE", "SQUA", "TRIA"};
		if (power_up)
		begin
			for (n = 0; n < init_groups; n++)
				items.push_back({3'b100, 7'(n)});
			for (n = 0; n < text_rows; n++)
			begin
				items.push_back({3'b100, 7'(init_groups + n)});
				items.push_back({3'b010, 7'd0});
			end
		end
		else
		begin
			script = {"|FRE:fffffffffHZ|AM:aaaaaMV|MOD:", words[label_idx]};
			grp = init_groups;
			fd = freq_digits;
			ad = amp_digits;
			for (n = 0; n < script.len(); n++)
			begin
				case (script[n])
					"|":
					begin
						items.push_back({3'b100, 7'(grp)});
						grp++;
					end
					"f", "a":
					begin
						if (script[n] == "f")
						begin
							fd--;
							nib = freq[4*fd +: 4];  // most significant first
						end
						else
						begin
							ad--;
							nib = amp[4*ad +: 4];
						end
						items.push_back(nib > 9 ? {3'b001, 7'd0} : {3'b000, 7'(nib)});
					end
					default: items.push_back({3'b000, char_code(script[n])});
				endcase
			end
		end
		foreach (items[n])
		begin
			if (items[n][8])
				repeat (clear_bytes) q.push_back(9'h100);
			else
			begin
				for (p = 0; p < glyph_bytes; p++)
				begin
					if (items[n][9])
						q.push_back({1'b0, cmd_group_byte(items[n][3:0], 3'(p))});
					else if (items[n][7])
						q.push_back(9'h100);
					else
						q.push_back({1'b1, font_byte(items[n][6:0], 3'(p))});
				end
			end
		end
		return q;
	endfunction

	function automatic logic [35:0] random_bcd(input int digits, input bit wild);
		logic [35:0] v;
		int d;
		v = '0;
		for (d = 0; d < digits; d++)
			v[4*d +: 4] = (wild && d % 2 == 0) ? 4'($urandom_range(15, 10)) :
				4'($urandom_range(9));
		return v;
	endfunction

	task automatic build_refs();
		stream_q q;
		int l;
		int n;
		for (l = 0; l < 3; l++)
		begin
			q = expected_stream(1'b0, freq_bcd, amp_bcd, l);
			for (n = 0; n < pass_len; n++)
				pass_ref[l*pass_len + n] = q[n];
		end
	endtask

	task automatic wait_passes(input int n, output bit reached);
		int cycles;
		cycles = 0;
		while (passes_done < n && !chk_finished && cycles < wait_limit)
		begin
			@(posedge clk_in);
			cycles++;
		end
		reached = (passes_done >= n);
		if (cycles >= wait_limit)
			$display("timeout: refresh pass %0d was not checked in time", n);
	endtask

	task automatic apply_change(input int step);
		@(posedge clk_in);
		#1;
		case (step)
			0: freq_bcd = random_bcd(freq_digits, 1'b0);
			1: amp_bcd = 20'(random_bcd(amp_digits, 1'b1));  // even digits above 9
			default:
			begin
				freq_bcd = random_bcd(freq_digits, 1'b1);
				amp_bcd = 20'(random_bcd(amp_digits, 1'b0));
			end
		endcase
		change_cnt++;
		build_refs();
		$display("inputs changed, freq_bcd %09h amp_bcd %05h", freq_bcd, amp_bcd);
	endtask

	task automatic wait_finished(output bit done_ok);
		int cycles;
		cycles = 0;
		while (!chk_finished && cycles < wait_limit)
		begin
			@(posedge clk_in);
			cycles++;
		end
		done_ok = chk_finished;
		if (!chk_finished)
			$display("timeout: checker did not finish its passes");
	endtask

	initial
	begin
		clk_in = 1'b0;
		forever
			#5 clk_in = ~clk_in;
	end

	initial
	begin
		void'($urandom(21));
		rst_n_in = 1'b0;
		change_cnt = 0;
		freq_bcd = random_bcd(freq_digits, 1'b0);
		amp_bcd = 20'(random_bcd(amp_digits, 1'b0));
		power_q = expected_stream(1'b1, '0, '0, 0);
		for (i = 0; i < power_len; i++)
			power_ref[i] = power_q[i];
		build_refs();
		repeat (8) @(posedge clk_in);
		#1;
		rst_n_in = 1'b1;
		ok = 1'b1;
		for (k = 0; k < 3 && ok; k++)
		begin
			wait_passes(4 * (k + 1), ok);
			if (ok)
				apply_change(k);
		end
		if (ok)
			wait_finished(ok);
		$display("tests run %0d, failed %0d", tests_run, tests_failed);
		if (ok && tests_failed == 0 && tests_run > 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule

// ==== oled_checker.sv ====
// panel scoreboard rebuilding bytes from the serial pins and comparing them with the reference
`timescale 1ns/10ps
module oled_checker #(
	parameter int power_len = 566,
	parameter int pass_len = 216,
	parameter int pass_goal = 18
) (
	input logic clk_in,
	input logic oled_rst_n,
	input logic oled_cs_n,
	input logic oled_dc,
	input logic oled_clk,
	input logic oled_data,
	input logic [8:0] power_ref [0:power_len-1],
	input logic [8:0] pass_ref [0:3*pass_len-1],
	input int change_cnt,
	output int passes_done,
	output int tests_run,
	output int tests_failed,
	output logic finished
);
	localparam int byte_wait = 1000;  // a byte needs about 180 clk_in cycles
	localparam int reset_wait = 200;

	logic [8:0] got [$];  // decoded {dc, data}
	logic [8:0] cap [0:power_len-1];
	logic [7:0] shifter;
	int bit_cnt;

	// panel samples on the rising clock and the ninth rise is the byte tail
	always @(posedge oled_clk)
	begin
		if (oled_cs_n)
			bit_cnt = 0;
		else
		begin
			if (bit_cnt < 8)
				shifter = {shifter[6:0], oled_data};
			bit_cnt++;
			if (bit_cnt == 8)
				got.push_back({oled_dc, shifter});
			else if (bit_cnt == 9)
				bit_cnt = 0;
		end
	end

	task automatic report(input string name, input bit good);
		tests_run++;
		if (!good)
			tests_failed++;
		$display("test %s %s", name, good ? "passed" : "failed");
	endtask

	task automatic collect(input int count, output bit ok);
		int cycles;
		int i;
		ok = 1'b1;
		for (i = 0; i < count && ok; i++)
		begin
			cycles = 0;
			while (got.size() == 0 && cycles < byte_wait)
			begin
				@(posedge clk_in);
				cycles++;
			end
			if (got.size() == 0)
			begin
				$display("ERROR: byte %0d did not appear on the panel pins in time", i);
				ok = 1'b0;
			end
			else
				cap[i] = got.pop_front();
		end
	endtask

	task automatic show_diff(input string name, input int idx, input logic [8:0] exp_b,
			input logic [8:0] act_b);
		$display("CHECK FAILED %s byte %0d expected dc=%0b data=%02h actual dc=%0b data=%02h",
			name, idx, exp_b[8], exp_b[7:0], act_b[8], act_b[7:0]);
	endtask

	task automatic run_checks();
		int cycles;
		int i;
		int l;
		int p;
		int best;
		int diff [3];
		int prev_label;
		int steps;  // label advances seen
		int snap;
		bit ok;
		bit first;
		bit saw_low;
		string name;
		cycles = 0;
		while (oled_rst_n !== 1'b0 && cycles < reset_wait)
		begin
			@(posedge clk_in);
			cycles++;
		end
		saw_low = (oled_rst_n === 1'b0);
		cycles = 0;
		while (oled_rst_n !== 1'b1 && cycles < reset_wait)
		begin
			@(posedge clk_in);
			cycles++;
		end
		if (!saw_low || oled_rst_n !== 1'b1)
		begin
			$display("ERROR: panel reset never went low and then high");
			report("power_up", 1'b0);
			return;
		end
		collect(power_len, ok);
		if (!ok)
		begin
			report("power_up", 1'b0);
			return;
		end
		best = power_len;
		for (i = power_len - 1; i >= 0; i--)
			if (cap[i] !== power_ref[i])
				best = i;
		if (best < power_len)
			show_diff("power_up", best, power_ref[best], cap[best]);
		report("power_up", best == power_len);
		snap = change_cnt;
		prev_label = 0;
		steps = 0;
		first = 1'b1;
		for (p = 1; p <= pass_goal; p++)
		begin
			name = $sformatf("pass_%0d", p);
			collect(pass_len, ok);
			if (!ok)
			begin
				report(name, 1'b0);
				return;
			end
			if (change_cnt != snap)
				$display("test %s skipped, inputs changed during the pass", name);
			else
			begin
				best = 0;
				for (l = 0; l < 3; l++)
				begin
					diff[l] = pass_len;
					for (i = pass_len - 1; i >= 0; i--)
						if (cap[i] !== pass_ref[l*pass_len + i])
							diff[l] = i;
					if (diff[l] > diff[best])
						best = l;  // closest label wins the report
				end
				if (diff[best] < pass_len)
				begin
					show_diff(name, diff[best], pass_ref[best*pass_len + diff[best]],
						cap[diff[best]]);
					report(name, 1'b0);
				end
				else if (best != prev_label && (first || best != (prev_label + 1) % 3))
				begin
					$display("ERROR: %s label %0d out of order after label %0d",
						name, best, prev_label);
					report(name, 1'b0);
				end
				else
				begin
					if (best != prev_label)
						steps++;
					prev_label = best;
					first = 1'b0;
					report(name, 1'b1);
				end
			end
			passes_done = p;
			snap = change_cnt;
		end
		if (steps < 3)
			$display("ERROR: label advanced %0d times, expected a full rotation", steps);
		report("label_rotation", steps >= 3);
	endtask

	initial
	begin
		passes_done = 0;
		tests_run = 0;
		tests_failed = 0;
		finished = 1'b0;
		bit_cnt = 0;
		run_checks();
		finished = 1'b1;
	end
endmodule

// ==== oled_sva.sv ====
// serializer pin assertions covering dc hold, data edge alignment and chip select after reset
`timescale 1ns/10ps
module oled_sva (
	input logic clk_in,
	input logic rst_n_in,
	input logic oled_cs_n,
	input logic oled_dc,
	input logic oled_clk,
	input logic oled_data
);
	// dc may only move with a falling panel clock, where the next byte loads
	dc_holds: assert property (@(posedge clk_in) disable iff (!rst_n_in)
		(!oled_cs_n && $past(!oled_cs_n) && !$fell(oled_clk)) |-> $stable(oled_dc))
		else $error("oled_dc moved while a byte was on the wire");

	data_on_fall: assert property (@(posedge clk_in) disable iff (!rst_n_in)
		!$stable(oled_data) |-> $fell(oled_clk))
		else $error("oled_data changed away from a falling panel clock");

	cs_high_after_reset: assert property (@(posedge clk_in)
		$rose(rst_n_in) |-> oled_cs_n)
		else $error("chip select low when reset was released");
endmodule

bind oled_serializer oled_sva serializer_sva (
	.clk_in(clk_in),
	.rst_n_in(rst_n_in),
	.oled_cs_n(oled_cs_n),
	.oled_dc(oled_dc),
	.oled_clk(oled_clk),
	.oled_data(oled_data)
);

// ==== oled_display_top.sv ====
// oled display top joining label rotator, sequencer, glyph expander and serializer
`timescale 1ns/10ps
module oled_display_top #(
	parameter int rotate_cycles = 100_000_000
) (
	input logic clk_in,
	input logic rst_n_in,
	input logic [4*oled_pkg::freq_digits-1:0] freq_bcd,
	input logic [4*oled_pkg::amp_digits-1:0] amp_bcd,
	output logic oled_rst_n,
	output logic oled_cs_n,
	output logic oled_dc,
	output logic oled_clk,
	output logic oled_data
);
	import oled_pkg::*;

	wave_label_e label;

	oled_item_if item_bus ();
	oled_byte_if byte_bus ();

	wave_label_rotator #(
		.rotate_cycles(rotate_cycles)
	) u_rotator (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.label(label)
	);

	screen_sequencer u_sequencer (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.freq_bcd(freq_bcd),
		.amp_bcd(amp_bcd),
		.label(label),
		.oled_rst_n(oled_rst_n),
		.item(item_bus.issuer)
	);

	glyph_expander u_expander (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.item(item_bus.expander),
		.byte_out(byte_bus.source)
	);

	oled_serializer u_serializer (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.byte_in(byte_bus.shifter),
		.oled_cs_n(oled_cs_n),
		.oled_dc(oled_dc),
		.oled_clk(oled_clk),
		.oled_data(oled_data)
	);
endmodule

// ==== oled_serializer.sv ====
// serializer dividing clk_in into the panel clock and shifting bytes out msb first
`timescale 1ns/10ps
module oled_serializer (
	input logic clk_in,
	input logic rst_n_in,
	oled_byte_if.shifter byte_in,
	output logic oled_cs_n,
	output logic oled_dc,
	output logic oled_clk,
	output logic oled_data
);
	import oled_pkg::*;

	typedef enum logic {ser_idle, ser_shift} ser_state_e;

	ser_state_e state;
	logic [$clog2(spi_div)-1:0] div_cnt;
	logic fall_edge;
	logic rise_edge;
	logic pending;     // byte accepted, waits for a falling edge
	logic [7:0] pend_data;
	logic pend_dc;
	logic [7:0] shift_reg;
	logic [3:0] bit_cnt;  // 8 after last rise, 9 in the tail period
	logic load;
	logic shift_now;

	assign fall_edge = (div_cnt == $bits(div_cnt)'(spi_div - 1));
	assign rise_edge = (div_cnt == $bits(div_cnt)'(spi_div / 2 - 1));
	assign load = fall_edge && pending && (state == ser_idle || bit_cnt == 4'd9);
	assign shift_now = fall_edge && (state == ser_shift) && (bit_cnt < 4'd8);

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			div_cnt <= '0;
			oled_clk <= 1'b0;
		end
		else
		begin
			div_cnt <= fall_edge ? '0 : div_cnt + 1'b1;
			if (fall_edge)
				oled_clk <= 1'b0;
			else if (rise_edge)
				oled_clk <= 1'b1;  // high for the second half
		end
	end

	always_ff @(posedge clk_in)
	begin
		if (byte_in.start)
		begin
			pend_data <= byte_in.data;
			pend_dc <= byte_in.dc;
		end
		if (load)
			shift_reg <= pend_data;
		else if (shift_now)
			shift_reg <= shift_reg << 1;
	end

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			state <= ser_idle;
			pending <= 1'b0;
			bit_cnt <= '0;
			oled_cs_n <= 1'b1;
			oled_dc <= 1'b0;
			oled_data <= 1'b0;
			byte_in.done <= 1'b0;
		end
		else
		begin
			byte_in.done <= 1'b0;
			if (byte_in.start)
				pending <= 1'b1;
			if (load)
			begin
				state <= ser_shift;
				pending <= 1'b0;
				bit_cnt <= '0;
				oled_cs_n <= 1'b0;
				oled_dc <= pend_dc;
				oled_data <= pend_data[7];
			end
			else if (state == ser_shift)
			begin
				if (rise_edge && bit_cnt < 4'd8)
					bit_cnt <= bit_cnt + 1'b1;  // panel samples here
				else if (shift_now)
					oled_data <= shift_reg[6];
				else if (fall_edge && bit_cnt == 4'd8)
				begin
					byte_in.done <= 1'b1;
					bit_cnt <= 4'd9;
				end
				else if (fall_edge)
				begin
					state <= ser_idle;  // no follow-up byte arrived
					oled_cs_n <= 1'b1;
					bit_cnt <= '0;
				end
			end
		end
	end
endmodule

// ==== glyph_expander.sv ====
// glyph expander turning one item into command, font or clear bytes for the serializer
`timescale 1ns/10ps
module glyph_expander (
	input logic clk_in,
	input logic rst_n_in,
	oled_item_if.expander item,
	oled_byte_if.source byte_out
);
	import oled_pkg::*;

	item_kind_e kind_r;
	glyph_code_t code_r;
	logic [6:0] byte_cnt;  // up to 127 for a row clear
	logic busy;
	logic last_byte;

	assign last_byte = (kind_r == item_clear) ? (byte_cnt == 7'(clear_bytes - 1)) :
		(byte_cnt == 7'(glyph_bytes - 1));

	always_comb
	begin
		case (kind_r)
			item_cmd:
			begin
				byte_out.data = cmd_group_byte(code_r[3:0], byte_cnt[2:0]);
				byte_out.dc = 1'b0;
			end
			item_glyph:
			begin
				byte_out.data = font_byte(code_r, byte_cnt[2:0]);
				byte_out.dc = 1'b1;
			end
			default:
			begin
				byte_out.data = 8'h00;  // blank column
				byte_out.dc = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk_in)
	begin
		if (item.start)
		begin
			kind_r <= item.kind;
			code_r <= item.code;
		end
	end

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			busy <= 1'b0;
			byte_cnt <= '0;
			byte_out.start <= 1'b0;
			item.done <= 1'b0;
		end
		else
		begin
			byte_out.start <= 1'b0;
			item.done <= 1'b0;
			if (item.start)
			begin
				busy <= 1'b1;
				byte_cnt <= '0;
				byte_out.start <= 1'b1;  // first byte right away
			end
			else if (busy && byte_out.done)
			begin
				if (last_byte)
				begin
					busy <= 1'b0;
					item.done <= 1'b1;
				end
				else
				begin
					byte_cnt <= byte_cnt + 1'b1;
					byte_out.start <= 1'b1;
				end
			end
		end
	end
endmodule

// ==== screen_sequencer.sv ====
// screen sequencer walking panel reset, init groups, row clear and the endless refresh pass
`timescale 1ns/10ps
module screen_sequencer (
	input logic clk_in,
	input logic rst_n_in,
	input logic [4*oled_pkg::freq_digits-1:0] freq_bcd,
	input logic [4*oled_pkg::amp_digits-1:0] amp_bcd,
	input oled_pkg::wave_label_e label,
	output logic oled_rst_n,
	oled_item_if.issuer item
);
	import oled_pkg::*;

	typedef enum logic [1:0] {reset_pulse, init, clear, refresh} seq_state_e;

	seq_state_e state;
	logic [5:0] step;
	logic busy;          // item out, waiting for done
	logic issue;
	logic last_step;
	logic pass_start;    // latch point for a new refresh pass
	item_kind_e nxt_kind;
	glyph_code_t nxt_code;
	logic nxt_freq;
	logic nxt_amp;
	logic [4*freq_digits-1:0] freq_sh;
	logic [4*amp_digits-1:0] amp_sh;
	wave_label_e label_r;

	assign issue = !busy && (state != reset_pulse);
	assign pass_start = busy && item.done && last_step && (state == clear || state == refresh);

	always_comb
	begin
		case (state)
			reset_pulse: last_step = (step == 6'd1);  // panel reset low two cycles
			init: last_step = (step == 6'(init_groups - 1));
			clear: last_step = (step == 6'(2 * text_rows - 1));
			default: last_step = (step == 6'd35);  // 16 + 11 + 9 items per pass
		endcase
	end

	always_comb
	begin
		nxt_kind = item_glyph;
		nxt_code = '0;
		nxt_freq = 1'b0;
		nxt_amp = 1'b0;
		case (state)
			init:
			begin
				nxt_kind = item_cmd;
				nxt_code = glyph_code_t'(step);
			end
			clear:
			begin
				nxt_kind = step[0] ? item_clear : item_cmd;  // position then zeros
				nxt_code = 7'd5 + glyph_code_t'(step[2:1]);
			end
			refresh:
				case (step) inside
					6'd0:
					begin
						nxt_kind = item_cmd;
						nxt_code = 7'd5;
					end
					6'd1: nxt_code = 7'd38;  // F
					6'd2: nxt_code = 7'd50;  // R
					6'd3: nxt_code = 7'd37;  // E
					6'd4, 6'd19, 6'd31: nxt_code = 7'd26;  // colon
					[6'd5:6'd13]:
					begin
						nxt_code = {3'b000, freq_sh[4*freq_digits-1 -: 4]};  // msd first
						nxt_freq = 1'b1;
					end
					6'd14: nxt_code = 7'd40;  // H
					6'd15: nxt_code = 7'd58;  // Z
					6'd16:
					begin
						nxt_kind = item_cmd;
						nxt_code = 7'd6;
					end
					6'd17: nxt_code = 7'd33;  // A
					6'd18, 6'd25, 6'd28: nxt_code = 7'd45;  // M
					[6'd20:6'd24]:
					begin
						nxt_code = {3'b000, amp_sh[4*amp_digits-1 -: 4]};
						nxt_amp = 1'b1;
					end
					6'd26: nxt_code = 7'd54;  // V
					6'd27:
					begin
						nxt_kind = item_cmd;
						nxt_code = 7'd7;
					end
					6'd29: nxt_code = 7'd47;  // O
					6'd30: nxt_code = 7'd36;  // D
					default: nxt_code = label_char(label_r, step[1:0]);  // steps 32 to 35
				endcase
			default: nxt_code = '0;
		endcase
	end

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			state <= reset_pulse;
			step <= '0;
			busy <= 1'b0;
			oled_rst_n <= 1'b0;
			item.start <= 1'b0;
		end
		else
		begin
			item.start <= 1'b0;
			if (state == reset_pulse)
			begin
				step <= step + 1'b1;
				if (last_step)
				begin
					oled_rst_n <= 1'b1;
					state <= init;
					step <= '0;
				end
			end
			else if (issue)
			begin
				item.start <= 1'b1;
				busy <= 1'b1;
			end
			else if (item.done)
			begin
				busy <= 1'b0;
				step <= last_step ? '0 : step + 1'b1;
				if (last_step && state == init)
					state <= clear;
				else if (last_step && state == clear)
					state <= refresh;
			end
		end
	end

	// whole pass is drawn from one snapshot of the inputs
	always_ff @(posedge clk_in)
	begin
		if (issue)
		begin
			item.kind <= nxt_kind;
			item.code <= nxt_code;
		end
		if (pass_start)
		begin
			freq_sh <= freq_bcd;
			amp_sh <= amp_bcd;
			label_r <= label;
		end
		else if (issue && nxt_freq)
			freq_sh <= freq_sh << 4;
		else if (issue && nxt_amp)
			amp_sh <= amp_sh << 4;
	end
endmodule

// ==== wave_label_rotator.sv ====
// waveform label rotator stepping through SINE, SQUA and TRIA on a cycle timer
`timescale 1ns/10ps
module wave_label_rotator #(
	parameter int rotate_cycles = 100_000_000
) (
	input logic clk_in,
	input logic rst_n_in,
	output oled_pkg::wave_label_e label
);
	import oled_pkg::*;

	logic [$clog2(rotate_cycles)-1:0] cnt;

	always_ff @(posedge clk_in or negedge rst_n_in)
	begin
		if (!rst_n_in)
		begin
			cnt <= '0;
			label <= label_sine;
		end
		else if (cnt == $bits(cnt)'(rotate_cycles - 1))
		begin
			cnt <= '0;
			case (label)
				label_sine: label <= label_squa;
				label_squa: label <= label_tria;
				default: label <= label_sine;
			endcase
		end
		else
			cnt <= cnt + 1'b1;
	end
endmodule

// ==== oled_byte_if.sv ====
// byte link carrying one panel byte from the glyph expander to the serializer
`timescale 1ns/10ps
interface oled_byte_if;
	logic [7:0] data;
	logic dc;     // low for command bytes
	logic start;  // one cycle strobe
	logic done;   // pulses after the last bit

	modport source (
		output data,
		output dc,
		output start,
		input done
	);

	modport shifter (
		input data,
		input dc,
		input start,
		output done
	);
endinterface

// ==== oled_item_if.sv ====
// item link carrying one display item from the screen sequencer to the glyph expander
`timescale 1ns/10ps
interface oled_item_if;
	import oled_pkg::*;

	item_kind_e kind;   // command group, glyph or row clear
	glyph_code_t code;  // group index when kind is item_cmd
	logic start;        // one cycle strobe
	logic done;         // item fully shifted out

	modport issuer (
		output kind,
		output code,
		output start,
		input done
	);

	modport expander (
		input kind,
		input code,
		input start,
		output done
	);
endinterface

// ==== oled_pkg.sv ====
// oled display package with sizes, item and label types, command table and font lookup
package oled_pkg;

	localparam int spi_div = 20;  // clk_in cycles per serial clock
	localparam int glyph_bytes = 6;
	localparam int clear_bytes = 128;
	localparam int init_groups = 5;
	localparam int text_rows = 4;
	localparam int freq_digits = 9;
	localparam int amp_digits = 5;

	typedef logic [6:0] glyph_code_t;  // 0-9 digits, 26 colon, 33 up capitals

	typedef enum logic [1:0] {item_cmd, item_glyph, item_clear} item_kind_e;

	typedef enum logic [1:0] {label_sine, label_squa, label_tria} wave_label_e;

	function automatic logic [7:0] cmd_group_byte(input logic [3:0] group, input logic [2:0] pos);
		logic [47:0] row;
		case (group)
			4'd0: row = 48'hae_00_10_00_b0_81;  // display off, column and page setup
			4'd1: row = 48'hff_a1_a6_a8_1f_c8;
			4'd2: row = 48'hd3_00_d5_80_d9_1f;
			4'd3: row = 48'hda_00_db_40_8d_14;  // charge pump on
			4'd4: row = 48'haf_e3_e3_e3_e3_e3;  // display on, rest are nops
			4'd5: row = 48'hb0_01_10_e3_e3_e3;  // row 1 position
			4'd6: row = 48'hb1_01_10_e3_e3_e3;
			4'd7: row = 48'hb2_01_10_e3_e3_e3;
			4'd8: row = 48'hb3_01_10_e3_e3_e3;  // row 4 position
			default: row = '0;
		endcase
		if (pos >= glyph_bytes)
			return 8'h00;
		return row[8 * (glyph_bytes - 1 - pos) +: 8];  // first byte sits in the top bits
	endfunction

	function automatic logic [7:0] font_byte(input glyph_code_t code, input logic [2:0] pos);
		logic [47:0] glyph;
		case (code)
			7'd0: glyph = 48'h00_3e_51_49_45_3e;
			7'd1: glyph = 48'h00_00_42_7f_40_00;
			7'd2: glyph = 48'h00_42_61_51_49_46;
			7'd3: glyph = 48'h00_21_41_45_4b_31;
			7'd4: glyph = 48'h00_18_14_12_7f_10;
			7'd5: glyph = 48'h00_27_45_45_45_39;
			7'd6: glyph = 48'h00_3c_4a_49_49_30;
			7'd7: glyph = 48'h00_01_71_09_05_03;
			7'd8: glyph = 48'h00_36_49_49_49_36;
			7'd9: glyph = 48'h00_06_49_49_29_1e;
			7'd26: glyph = 48'h00_00_36_36_00_00;  // colon
			7'd33: glyph = 48'h00_7c_12_11_12_7c;  // A
			7'd36: glyph = 48'h00_7f_41_41_22_1c;  // D
			7'd37: glyph = 48'h00_7f_49_49_49_41;  // E
			7'd38: glyph = 48'h00_7f_09_09_09_01;  // F
			7'd40: glyph = 48'h00_7f_08_08_08_7f;  // H
			7'd41: glyph = 48'h00_00_41_7f_41_00;  // I
			7'd45: glyph = 48'h00_7f_02_0c_02_7f;  // M
			7'd46: glyph = 48'h00_7f_04_08_10_7f;  // N
			7'd47: glyph = 48'h00_3e_41_41_41_3e;  // O
			7'd49: glyph = 48'h00_3e_41_51_21_5e;  // Q
			7'd50: glyph = 48'h00_7f_09_19_29_46;  // R
			7'd51: glyph = 48'h00_46_49_49_49_31;  // S
			7'd52: glyph = 48'h00_01_01_7f_01_01;  // T
			7'd53: glyph = 48'h00_3f_40_40_40_3f;  // U
			7'd54: glyph = 48'h00_1f_20_40_20_1f;  // V
			7'd58: glyph = 48'h00_61_51_49_45_43;  // Z
			default: glyph = '0;  // blank cell, covers bcd 10 to 15
		endcase
		if (pos >= glyph_bytes)
			return 8'h00;
		return glyph[8 * (glyph_bytes - 1 - pos) +: 8];
	endfunction

	function automatic glyph_code_t label_char(input wave_label_e label, input logic [1:0] pos);
		logic [27:0] codes;
		case (label)
			label_sine: codes = {7'd51, 7'd41, 7'd46, 7'd37};
			label_squa: codes = {7'd51, 7'd49, 7'd53, 7'd33};
			default: codes = {7'd52, 7'd50, 7'd41, 7'd33};  // TRIA
		endcase
		return codes[7 * (3 - pos) +: 7];
	endfunction

endpackage
